//--- include/wb_soc_map.svh
`ifndef WB_SOC_MAP_SVH
`define WB_SOC_MAP_SVH

// Top address byte of each slave region
`define WB_SOC_RAM_BASE 8'h00
`define WB_SOC_UART_BASE 8'h90

// RAM size as a power of two in words
`define WB_SOC_RAM_SIZE_BITS 10
`define WB_SOC_RAM_SIZE_BYTES ((1 << `WB_SOC_RAM_SIZE_BITS) * 4)

// UART register word offsets
`define WB_SOC_UART_THR 2'd0
`define WB_SOC_UART_LSR 2'd1
`define WB_SOC_UART_IER 2'd2
`define WB_SOC_UART_DIV 2'd3

`endif

//--- logic/wb_arbiter.sv
`default_nettype none

module wb_arbiter (
	input  logic                wb_clk_i,
	input  logic                rst_n_i,
	input  wb_soc_pkg::wb_m2s_t cpu_req_i,
	input  wb_soc_pkg::wb_m2s_t dbg_req_i,
	output wb_soc_pkg::wb_s2m_t cpu_rsp_o,
	output wb_soc_pkg::wb_s2m_t dbg_rsp_o,
	output wb_soc_pkg::wb_m2s_t bus_req_o,
	input  wb_soc_pkg::wb_s2m_t bus_rsp_i
);

	import wb_soc_pkg::*;

	wb_master_e owner_q;
	wb_master_e last_q;
	wb_master_e next_owner;
	logic       busy_q;
	logic       cpu_want;
	logic       dbg_want;
	logic       cycle_done;

	assign cpu_want = cpu_req_i.cyc & cpu_req_i.stb;
	assign dbg_want = dbg_req_i.cyc & dbg_req_i.stb;
	assign cycle_done = bus_rsp_i.ack | bus_rsp_i.err;

	// Round robin, the master that did not own last wins a tie
	always_comb begin
		if (cpu_want && dbg_want) begin
			next_owner = (last_q == MST_CPU) ? MST_DBG : MST_CPU;
		end else if (dbg_want) begin
			next_owner = MST_DBG;
		end else begin
			next_owner = MST_CPU;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Ownership
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			owner_q <= MST_CPU;
			// Processor wins the first tie after reset
			last_q <= MST_DBG;
		end else if (busy_q) begin
			if (cycle_done) begin
				busy_q <= 1'b0;
				last_q <= owner_q;
			end
		end else if (cpu_want || dbg_want) begin
			busy_q <= 1'b1;
			owner_q <= next_owner;
		end
	end

	// Owner's request onto the shared bus
	always_comb begin
		bus_req_o = (owner_q == MST_DBG) ? dbg_req_i : cpu_req_i;
		bus_req_o.cyc = bus_req_o.cyc & busy_q;
		bus_req_o.stb = bus_req_o.stb & busy_q;
	end

	// Response goes back to the owner only
	always_comb begin
		cpu_rsp_o = '0;
		dbg_rsp_o = '0;
		if (busy_q) begin
			if (owner_q == MST_DBG) begin
				dbg_rsp_o = bus_rsp_i;
			end else begin
				cpu_rsp_o = bus_rsp_i;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/wb_decoder.sv
`default_nettype none

module wb_decoder (
	input  logic                wb_clk_i,
	input  logic                rst_n_i,
	input  wb_soc_pkg::wb_m2s_t bus_req_i,
	output wb_soc_pkg::wb_s2m_t bus_rsp_o,
	output wb_soc_pkg::wb_m2s_t ram_req_o,
	output wb_soc_pkg::wb_m2s_t uart_req_o,
	input  wb_soc_pkg::wb_s2m_t ram_rsp_i,
	input  wb_soc_pkg::wb_s2m_t uart_rsp_i
);

	import wb_soc_pkg::*;

	logic [7:0] top_byte;
	logic       sel_ram;
	logic       sel_uart;
	logic       unmapped;
	logic       req_valid;
	logic       err_q;

	assign top_byte = bus_req_i.adr[WB_AW-1 -: 8];
	assign sel_ram = (top_byte == RAM_BASE);
	assign sel_uart = (top_byte == UART_BASE);
	assign unmapped = !sel_ram && !sel_uart;
	assign req_valid = bus_req_i.cyc & bus_req_i.stb;

	////////////////////////////////////////////////////////////////////////////
	// Request fan-out
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		ram_req_o = bus_req_i;
		ram_req_o.cyc = bus_req_i.cyc & sel_ram;
		ram_req_o.stb = bus_req_i.stb & sel_ram;

		uart_req_o = bus_req_i;
		uart_req_o.cyc = bus_req_i.cyc & sel_uart;
		uart_req_o.stb = bus_req_i.stb & sel_uart;
	end

	// Error reply for holes in the map, single pulse per cycle
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req_valid & unmapped & ~err_q;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Response combining
	////////////////////////////////////////////////////////////////////////////
	// Address is held until ack, so the live selection still matches
	always_comb begin
		bus_rsp_o = '0;
		if (sel_ram) begin
			bus_rsp_o.dat = ram_rsp_i.dat;
		end else if (sel_uart) begin
			bus_rsp_o.dat = uart_rsp_i.dat;
		end
		bus_rsp_o.ack = (sel_ram & ram_rsp_i.ack) | (sel_uart & uart_rsp_i.ack);
		bus_rsp_o.err = err_q | (sel_ram & ram_rsp_i.err) | (sel_uart & uart_rsp_i.err);
	end

endmodule

`default_nettype wire

//--- logic/wb_ram.sv
`default_nettype none

module wb_ram (
	input  logic                wb_clk_i,
	input  logic                rst_n_i,
	input  wb_soc_pkg::wb_m2s_t req_i,
	output wb_soc_pkg::wb_s2m_t rsp_o
);

	import wb_soc_pkg::*;

	wb_dat_t  mem [2**MEM_SIZE_BITS];
	wb_dat_t  rdata_q;
	mem_idx_t idx;
	logic     ack_q;
	logic     hit;

	// Word index, upper address bits wrap
	assign idx = req_i.adr[MEM_SIZE_BITS+1:2];

	// New access only when the previous ack has gone
	assign hit = req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
		end
	end

	// Byte lane writes
	always_ff @(posedge wb_clk_i) begin
		if (hit && req_i.we) begin
			for (int b = 0; b < WB_SW; b++) begin
				if (req_i.sel[b]) begin
					mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (hit && !req_i.we) begin
			rdata_q <= mem[idx];
		end
	end

	always_comb begin
		rsp_o.dat = rdata_q;
		rsp_o.ack = ack_q;
		rsp_o.err = 1'b0;
	end

endmodule

`default_nettype wire

//--- logic/wb_soc_pkg.sv
`default_nettype none

package wb_soc_pkg;

	`include "wb_soc_map.svh"

	// Bus geometry
	localparam int WB_AW = 32;
	localparam int WB_DW = 32;
	localparam int WB_SW = 4;

	localparam int MEM_SIZE_BITS = `WB_SOC_RAM_SIZE_BITS;
	localparam int IRQ_W = 20;
	localparam int UART_IRQ_LINE = 2;
	localparam int UART_FIFO_DEPTH = 8;
	localparam int UART_FIFO_AW = $clog2(UART_FIFO_DEPTH);
	localparam int UART_DIV_W = 16;

	// Address map
	localparam logic [7:0] RAM_BASE = `WB_SOC_RAM_BASE;
	localparam logic [7:0] UART_BASE = `WB_SOC_UART_BASE;
	localparam logic [1:0] UART_THR_OFF = `WB_SOC_UART_THR;
	localparam logic [1:0] UART_LSR_OFF = `WB_SOC_UART_LSR;
	localparam logic [1:0] UART_IER_OFF = `WB_SOC_UART_IER;
	localparam logic [1:0] UART_DIV_OFF = `WB_SOC_UART_DIV;

	typedef logic [WB_AW-1:0] wb_adr_t;
	typedef logic [WB_DW-1:0] wb_dat_t;
	typedef logic [WB_SW-1:0] wb_sel_t;
	typedef logic [MEM_SIZE_BITS-1:0] mem_idx_t;
	typedef logic [IRQ_W-1:0] irq_vec_t;
	typedef logic [7:0] uart_byte_t;
	typedef logic [UART_DIV_W-1:0] uart_div_t;
	typedef logic [UART_FIFO_AW-1:0] fifo_ptr_t;
	typedef logic [UART_FIFO_AW:0] fifo_cnt_t;

	// Wishbone classic request and response
	typedef struct packed {
		wb_adr_t adr;
		wb_dat_t dat;
		wb_sel_t sel;
		logic    we;
		logic    cyc;
		logic    stb;
	} wb_m2s_t;

	typedef struct packed {
		wb_dat_t dat;
		logic    ack;
		logic    err;
	} wb_s2m_t;

	typedef enum logic {
		MST_CPU = 1'b0,
		MST_DBG = 1'b1
	} wb_master_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

endpackage

`default_nettype wire

//--- logic/wb_soc_top.sv
`default_nettype none

module wb_soc_top (
	input  logic                 wb_clk_i,
	input  logic                 rst_n_i,
	input  wb_soc_pkg::wb_m2s_t  cpu_req_i,
	input  wb_soc_pkg::wb_m2s_t  dbg_req_i,
	output wb_soc_pkg::wb_s2m_t  cpu_rsp_o,
	output wb_soc_pkg::wb_s2m_t  dbg_rsp_o,
	output wb_soc_pkg::irq_vec_t irq_o,
	output logic                 stx_o
);

	import wb_soc_pkg::*;

	wb_m2s_t bus_req;
	wb_s2m_t bus_rsp;
	wb_m2s_t ram_req;
	wb_s2m_t ram_rsp;
	wb_m2s_t uart_req;
	wb_s2m_t uart_rsp;
	logic    uart_irq;

	////////////////////////////////////////////////////////////////////////////
	// Shared interconnect
	////////////////////////////////////////////////////////////////////////////
	wb_arbiter wb_arbiter_inst (
		.wb_clk_i  (wb_clk_i),
		.rst_n_i   (rst_n_i),
		.cpu_req_i (cpu_req_i),
		.dbg_req_i (dbg_req_i),
		.cpu_rsp_o (cpu_rsp_o),
		.dbg_rsp_o (dbg_rsp_o),
		.bus_req_o (bus_req),
		.bus_rsp_i (bus_rsp)
	);

	wb_decoder wb_decoder_inst (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.bus_req_i  (bus_req),
		.bus_rsp_o  (bus_rsp),
		.ram_req_o  (ram_req),
		.uart_req_o (uart_req),
		.ram_rsp_i  (ram_rsp),
		.uart_rsp_i (uart_rsp)
	);

	////////////////////////////////////////////////////////////////////////////
	// Slaves
	////////////////////////////////////////////////////////////////////////////
	wb_ram wb_ram_inst (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.req_i    (ram_req),
		.rsp_o    (ram_rsp)
	);

	wb_uart_tx wb_uart_tx_inst (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.req_i    (uart_req),
		.rsp_o    (uart_rsp),
		.irq_o    (uart_irq),
		.stx_o    (stx_o)
	);

	// Interrupt vector, only the UART line is in use
	always_comb begin
		irq_o = '0;
		irq_o[UART_IRQ_LINE] = uart_irq;
	end

endmodule

`default_nettype wire

//--- logic/wb_uart_tx.sv
`default_nettype none

module wb_uart_tx (
	input  logic                wb_clk_i,
	input  logic                rst_n_i,
	input  wb_soc_pkg::wb_m2s_t req_i,
	output wb_soc_pkg::wb_s2m_t rsp_o,
	output logic                irq_o,
	output logic                stx_o
);

	import wb_soc_pkg::*;

	uart_byte_t fifo_mem [UART_FIFO_DEPTH];
	fifo_ptr_t  wr_ptr_q;
	fifo_ptr_t  rd_ptr_q;
	fifo_cnt_t  count_q;
	logic       fifo_empty;
	logic       fifo_full;
	logic       push;
	logic       pop;

	uart_div_t  div_q;
	logic       ier_q;
	logic       ovf_q;
	logic       ack_q;
	wb_dat_t    rdata_q;
	logic       access;
	logic [1:0] reg_off;

	tx_state_e  state_q;
	uart_div_t  baud_cnt_q;
	logic [2:0] bit_cnt_q;
	uart_byte_t shift_q;
	logic       baud_zero;
	logic       tx_idle;

	assign reg_off = req_i.adr[3:2];
	assign access = req_i.cyc & req_i.stb & ~ack_q;
	assign fifo_empty = (count_q == '0);
	assign fifo_full = (count_q == fifo_cnt_t'(UART_FIFO_DEPTH));
	assign push = access & req_i.we & (reg_off == UART_THR_OFF) & ~fifo_full;
	assign baud_zero = (baud_cnt_q == '0);
	assign tx_idle = (state_q == TX_IDLE);

	// Next frame starts from idle or straight after a stop bit
	assign pop = ~fifo_empty & (tx_idle | ((state_q == TX_STOP) & baud_zero));

	////////////////////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			div_q <= '0;
			ier_q <= 1'b0;
			ovf_q <= 1'b0;
		end else begin
			ack_q <= req_i.cyc & req_i.stb & ~ack_q;
			if (access && req_i.we) begin
				case (reg_off)
					// Full FIFO drops the byte, bus is never stalled
					UART_THR_OFF: if (fifo_full) ovf_q <= 1'b1;
					UART_IER_OFF: ier_q <= req_i.dat[0];
					UART_DIV_OFF: div_q <= req_i.dat[UART_DIV_W-1:0];
					default: ;
				endcase
			end
			if (access && !req_i.we && reg_off == UART_LSR_OFF) begin
				ovf_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (access && !req_i.we) begin
			rdata_q <= '0;
			case (reg_off)
				UART_LSR_OFF: rdata_q[3:0] <= {ovf_q, tx_idle, fifo_full, fifo_empty};
				UART_IER_OFF: rdata_q[0] <= ier_q;
				UART_DIV_OFF: rdata_q[UART_DIV_W-1:0] <= div_q;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Holding FIFO
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i) begin
		if (push) begin
			fifo_mem[wr_ptr_q] <= req_i.dat[7:0];
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Serial shifter, 8N1
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			state_q <= TX_IDLE;
			baud_cnt_q <= '0;
			bit_cnt_q <= '0;
		end else begin
			if (!tx_idle) begin
				baud_cnt_q <= baud_zero ? div_q : baud_cnt_q - 1'b1;
			end
			case (state_q)
				TX_IDLE: begin
					if (pop) begin
						state_q <= TX_START;
						baud_cnt_q <= div_q;
					end
				end
				TX_START: begin
					if (baud_zero) begin
						state_q <= TX_DATA;
						bit_cnt_q <= '0;
					end
				end
				TX_DATA: begin
					if (baud_zero) begin
						if (bit_cnt_q == 3'd7) state_q <= TX_STOP;
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end
				TX_STOP: begin
					if (baud_zero) state_q <= pop ? TX_START : TX_IDLE;
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge wb_clk_i) begin
		if (pop) begin
			shift_q <= fifo_mem[rd_ptr_q];
		end else if (state_q == TX_DATA && baud_zero) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_comb begin
		case (state_q)
			TX_START: stx_o = 1'b0;
			TX_DATA: stx_o = shift_q[0];
			default: stx_o = 1'b1;
		endcase
	end

	// Interrupt once everything has gone out
	assign irq_o = ier_q & fifo_empty & tx_idle;

	always_comb begin
		rsp_o.dat = rdata_q;
		rsp_o.ack = ack_q;
		rsp_o.err = 1'b0;
	end

endmodule

`default_nettype wire

//--- testbench/wb_soc_tb.sv
`default_nettype none

`include "wb_soc_map.svh"

module wb_soc_tb;

	import wb_soc_pkg::*;

	localparam int RAM_WORDS = 12;
	localparam int MIX_N = 6;
	localparam int TX_BYTES = 8;
	localparam int TX_DIV = 3;
	localparam int OVF_WRITES = 12;
	localparam int OVF_DIV = 11;
	// Serial frames of both UART tests plus about 150 bus accesses at 8 cycles each
	localparam int SERIAL_CYCLES = TX_BYTES * 10 * (TX_DIV + 1)
		+ (UART_FIFO_DEPTH + 1) * 10 * (OVF_DIV + 1);
	localparam int TIMEOUT_CYCLES = (SERIAL_CYCLES + 150 * 8) * 3 / 2;

	logic       wb_clk = 1'b0;
	logic       rst_n = 1'b0;
	wb_m2s_t    cpu_req = '0;
	wb_m2s_t    dbg_req = '0;
	wb_s2m_t    cpu_rsp;
	wb_s2m_t    dbg_rsp;
	irq_vec_t   irq;
	logic       stx;

	integer     seed = 66;
	int         pass_cnt = 0;
	int         fail_cnt = 0;
	int         test_base = 0;
	int         cycles = 0;
	int         cur_div = 0;
	wb_dat_t    shadow [2**MEM_SIZE_BITS];
	mem_idx_t   mix_idx [2][MIX_N];
	wb_dat_t    mix_dat [2][MIX_N];
	uart_byte_t tx_exp [$];
	wb_master_e done_order [$];
	mem_idx_t   written [$];

	wb_soc_top wb_soc_top_inst (
		.wb_clk_i  (wb_clk),
		.rst_n_i   (rst_n),
		.cpu_req_i (cpu_req),
		.dbg_req_i (dbg_req),
		.cpu_rsp_o (cpu_rsp),
		.dbg_rsp_o (dbg_rsp),
		.irq_o     (irq),
		.stx_o     (stx)
	);

	always #4 wb_clk = ~wb_clk;

	task automatic flag_error(input string what);
		fail_cnt++;
		$display("[FAIL] t=%0t %s", $time, what);
	endtask

	task automatic check(input logic ok, input string what);
		assert (ok) pass_cnt++;
		else flag_error(what);
	endtask

	task automatic end_test(input string name);
		$display("test %-12s done, %0d failures", name, fail_cnt - test_base);
		test_base = fail_cnt;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus masters
	////////////////////////////////////////////////////////////////////////////
	task automatic drive(input wb_master_e m, input wb_m2s_t req);
		if (m == MST_DBG) dbg_req = req;
		else cpu_req = req;
	endtask

	// Classic single cycle access
	// Latency counts clock edges from stb until ack or err
	task automatic bus_access(input wb_master_e m, input wb_adr_t adr, input wb_dat_t wdat,
			input wb_sel_t sel, input logic we, output wb_s2m_t rsp, output int lat);
		wb_m2s_t req;
		req = '{adr: adr, dat: wdat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
		@(negedge wb_clk);
		drive(m, req);
		lat = -1;
		do begin
			@(posedge wb_clk);
			lat++;
			rsp = (m == MST_DBG) ? dbg_rsp : cpu_rsp;
		end while (!(rsp.ack || rsp.err));
		done_order.push_back(m);
		@(negedge wb_clk);
		drive(m, '0);
	endtask

	// Bits above the word index repeat part of it and must be ignored by the RAM
	function automatic wb_adr_t ram_adr(input mem_idx_t idx);
		return {`WB_SOC_RAM_BASE, 10'h0, idx[1:0], idx, 2'b00};
	endfunction

	task automatic ram_write(input wb_master_e m, input mem_idx_t idx, input wb_dat_t d,
			input wb_sel_t sel, input logic idle_bus);
		wb_s2m_t rsp;
		int lat;
		bus_access(m, ram_adr(idx), d, sel, 1'b1, rsp, lat);
		check(rsp.ack && !rsp.err, $sformatf("RAM write to word %0d not acked", idx));
		if (idle_bus) check(lat == 2, $sformatf("RAM write latency %0d, expected 2", lat));
		for (int b = 0; b < WB_SW; b++) begin
			if (sel[b]) shadow[idx][8*b +: 8] = d[8*b +: 8];
		end
	endtask

	task automatic ram_read(input wb_master_e m, input mem_idx_t idx, input logic idle_bus);
		wb_s2m_t rsp;
		int lat;
		bus_access(m, ram_adr(idx), '0, 4'hF, 1'b0, rsp, lat);
		check(rsp.ack && !rsp.err, $sformatf("RAM read of word %0d not acked", idx));
		if (idle_bus) check(lat == 2, $sformatf("RAM read latency %0d, expected 2", lat));
		check(rsp.dat === shadow[idx],
			$sformatf("RAM word %0d read %h, expected %h", idx, rsp.dat, shadow[idx]));
	endtask

	// Each master keeps to its own half of the RAM
	task automatic mixed_traffic(input wb_master_e m);
		for (int k = 0; k < MIX_N; k++) begin
			ram_write(m, mix_idx[int'(m)][k], mix_dat[int'(m)][k], 4'hF, 1'b0);
			ram_read(m, mix_idx[int'(m)][k], 1'b0);
			written.push_back(mix_idx[int'(m)][k]);
		end
	endtask

	task automatic unmapped_access(input wb_master_e m, input logic we);
		wb_s2m_t rsp;
		int lat;
		logic [7:0] top;
		top = `WB_SOC_RAM_BASE;
		while (top == `WB_SOC_RAM_BASE || top == `WB_SOC_UART_BASE) begin
			top = 8'($random(seed));
		end
		bus_access(m, {top, 24'($random(seed))}, 32'($random(seed)), 4'hF, we, rsp, lat);
		check(rsp.err && !rsp.ack, $sformatf("top byte %h not answered with err", top));
		check(lat == 2 && rsp.dat == '0, $sformatf("err for top byte %h late or with data", top));
	endtask

	task automatic uart_write(input logic [1:0] off, input wb_dat_t d);
		wb_s2m_t rsp;
		int lat;
		bus_access(MST_CPU, {`WB_SOC_UART_BASE, 20'h0, off, 2'b00}, d, 4'hF, 1'b1, rsp, lat);
		check(rsp.ack && !rsp.err && lat == 2, $sformatf("UART write to offset %0d failed", off));
		if (off == `WB_SOC_UART_DIV) cur_div = int'(d[15:0]);
	endtask

	task automatic uart_read(input logic [1:0] off, output wb_dat_t d);
		wb_s2m_t rsp;
		int lat;
		bus_access(MST_DBG, {`WB_SOC_UART_BASE, 20'h0, off, 2'b00}, '0, 4'hF, 1'b0, rsp, lat);
		check(rsp.ack && !rsp.err && lat == 2, $sformatf("UART read of offset %0d failed", off));
		d = rsp.dat;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Protocol assertions
	////////////////////////////////////////////////////////////////////////////
	assert property (@(posedge wb_clk) disable iff (!rst_n)
			!(cpu_rsp.ack && cpu_rsp.err) && !(dbg_rsp.ack && dbg_rsp.err))
		else flag_error("ack and err raised together");
	assert property (@(posedge wb_clk) disable iff (!rst_n) cpu_rsp.ack |=> !cpu_rsp.ack)
		else flag_error("processor ack lasted more than one cycle");
	assert property (@(posedge wb_clk) disable iff (!rst_n) dbg_rsp.ack |=> !dbg_rsp.ack)
		else flag_error("debug ack lasted more than one cycle");
	assert property (@(posedge wb_clk) disable iff (!rst_n)
			!((cpu_rsp.ack || cpu_rsp.err) && (dbg_rsp.ack || dbg_rsp.err)))
		else flag_error("response seen on both masters at once");
	assert property (@(posedge wb_clk) disable iff (!rst_n)
			(cpu_rsp.ack || cpu_rsp.err) |-> cpu_req.stb)
		else flag_error("processor got a response it did not ask for");
	assert property (@(posedge wb_clk) disable iff (!rst_n)
			(dbg_rsp.ack || dbg_rsp.err) |-> dbg_req.stb)
		else flag_error("debug port got a response it did not ask for");
	assert property (@(posedge wb_clk) disable iff (!rst_n)
			(irq & ~(irq_vec_t'(1) << UART_IRQ_LINE)) == '0)
		else flag_error("interrupt line other than the UART one raised");

	// Serial receiver sampling mid-bit after the falling start edge
	initial begin : serial_monitor
		uart_byte_t rx;
		int bit_cycles;
		forever begin
			@(negedge stx);
			bit_cycles = cur_div + 1;
			repeat ((bit_cycles + 1) / 2) @(posedge wb_clk);
			check(stx == 1'b0, "UART start bit not low at mid-bit");
			for (int i = 0; i < 8; i++) begin
				repeat (bit_cycles) @(posedge wb_clk);
				rx[i] = stx;
			end
			repeat (bit_cycles) @(posedge wb_clk);
			check(stx == 1'b1, "UART stop bit not high");
			if (tx_exp.size() == 0) begin
				flag_error($sformatf("UART sent byte %h that was never expected", rx));
			end else begin
				check(rx == tx_exp[0], $sformatf("UART sent %h, expected %h", rx, tx_exp[0]));
				void'(tx_exp.pop_front());
			end
		end
	end

	initial begin : watchdog
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge wb_clk);
			cycles++;
		end
		$display("Timeout: the run did not end within %0d cycles, something hung", cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin : main
		mem_idx_t ram_idx [RAM_WORDS];
		uart_byte_t b;
		wb_dat_t d;
		repeat (4) @(posedge wb_clk);
		@(negedge wb_clk);
		rst_n = 1'b1;

		repeat (6) begin
			@(posedge wb_clk);
			check(irq == '0 && stx == 1'b1, "interrupt or serial line not idle after reset");
			check(!cpu_rsp.ack && !cpu_rsp.err && !dbg_rsp.ack && !dbg_rsp.err,
				"response without a request after reset");
		end
		end_test("reset");

		// Full words first and then random byte lanes from both masters
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram_idx[i] = mem_idx_t'($random(seed));
			ram_write(MST_CPU, ram_idx[i], 32'($random(seed)), 4'hF, 1'b1);
		end
		for (int i = 0; i < 2 * RAM_WORDS; i++) begin
			ram_write(wb_master_e'(i % 2), ram_idx[$unsigned($random(seed)) % RAM_WORDS],
				32'($random(seed)), wb_sel_t'($random(seed)), 1'b1);
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram_read(wb_master_e'(i % 2), ram_idx[i], 1'b1);
		end
		end_test("ram");

		for (int m = 0; m < 2; m++) begin
			for (int k = 0; k < MIX_N; k++) begin
				mix_idx[m][k] = {m[0], 9'($random(seed))};
				mix_dat[m][k] = 32'($random(seed));
			end
		end
		done_order.delete();
		// The processor owns last, so the debug port must win the tie that follows
		ram_read(MST_CPU, ram_idx[0], 1'b1);
		fork
			mixed_traffic(MST_CPU);
			mixed_traffic(MST_DBG);
		join
		check(done_order.size() == 4 * MIX_N + 1, "contention lost a completion");
		for (int i = 1; i < done_order.size(); i++) begin
			check(done_order[i] != done_order[i-1],
				$sformatf("completion %0d did not alternate masters", i));
		end
		foreach (written[i]) ram_read(MST_CPU, written[i], 1'b1);
		end_test("contention");

		unmapped_access(MST_CPU, 1'b1);
		unmapped_access(MST_CPU, 1'b0);
		unmapped_access(MST_DBG, 1'b1);
		unmapped_access(MST_DBG, 1'b0);
		end_test("unmapped");

		uart_write(`WB_SOC_UART_DIV, TX_DIV);
		for (int i = 0; i < TX_BYTES; i++) begin
			b = uart_byte_t'($random(seed));
			tx_exp.push_back(b);
			uart_write(`WB_SOC_UART_THR, {24'h0, b});
		end
		while (tx_exp.size() != 0) @(negedge wb_clk);
		repeat (10 * (TX_DIV + 1)) @(posedge wb_clk);
		uart_read(`WB_SOC_UART_LSR, d);
		check(d == 32'h5, $sformatf("LSR %h after drain, expected empty and idle", d));
		check(irq == '0, "interrupt raised while IER is clear");
		end_test("uart_serial");

		uart_write(`WB_SOC_UART_DIV, OVF_DIV);
		for (int i = 0; i < OVF_WRITES; i++) begin
			b = uart_byte_t'($random(seed));
			// The first byte goes straight to the shifter and the FIFO holds the next eight
			if (i <= UART_FIFO_DEPTH) tx_exp.push_back(b);
			uart_write(`WB_SOC_UART_THR, {24'h0, b});
		end
		uart_read(`WB_SOC_UART_LSR, d);
		check(d == 32'hA, $sformatf("LSR %h, expected overflow, full and busy", d));
		uart_read(`WB_SOC_UART_LSR, d);
		check(d == 32'h2, $sformatf("LSR %h, overflow not cleared by the read", d));
		uart_read(`WB_SOC_UART_DIV, d);
		check(d == OVF_DIV, $sformatf("DIV read %0d, expected %0d", d, OVF_DIV));
		uart_write(`WB_SOC_UART_IER, 32'h1);
		@(posedge wb_clk);
		check(irq[UART_IRQ_LINE] == 1'b0, "UART interrupt while still sending");
		while (tx_exp.size() != 0) @(negedge wb_clk);
		@(posedge wb_clk);
		check(irq[UART_IRQ_LINE] == 1'b0, "UART interrupt before the stop bit ended");
		repeat (OVF_DIV + 1) @(posedge wb_clk);
		check(irq[UART_IRQ_LINE] == 1'b1, "UART interrupt did not rise after draining");
		// Dropped bytes would show up here as unexpected frames
		repeat (10 * (OVF_DIV + 1)) @(posedge wb_clk);
		end_test("uart_status");

		$display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- wb_soc.f
+incdir+include
logic/wb_soc_pkg.sv
logic/wb_arbiter.sv
logic/wb_decoder.sv
logic/wb_ram.sv
logic/wb_uart_tx.sv
logic/wb_soc_top.sv
testbench/wb_soc_tb.sv
